// ==== hw/rv_pkg.sv ====
package rv_pkg;

    // data path width and the width of the byte addresses on the memory ports.
    localparam int xlen = 32;
    localparam int addr_width = 10;

    // register file geometry.
    localparam int reg_addr_width = 5;
    localparam int reg_count = 32;

    // shift amounts use only the low bits of the second operand.
    localparam int shamt_width = 5;

    // major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_e;

    // first ALU operand source. a_pc serves AUIPC and a_zero serves LUI.
    typedef enum logic [1:0] {
        a_rs1,
        a_pc,
        a_zero
    } a_src_e;

    typedef enum logic {
        wb_alu,
        wb_mem
    } wb_src_e;

endpackage

// ==== hw/rv_alu.sv ====
`timescale 1ns/100ps

module rv_alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_e         op,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    zero
);

    logic [rv_pkg::shamt_width-1:0] shamt;
    logic                           less;

    assign shamt = b[rv_pkg::shamt_width-1:0];

    // set-less-than compares the operands as signed values.
    assign less = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            rv_pkg::alu_add: result = a + b;
            rv_pkg::alu_sub: result = a - b;
            rv_pkg::alu_and: result = a & b;
            rv_pkg::alu_or:  result = a | b;
            rv_pkg::alu_xor: result = a ^ b;
            rv_pkg::alu_slt: result = {{(rv_pkg::xlen-1){1'b0}}, less};
            rv_pkg::alu_sll: result = a << shamt;
            rv_pkg::alu_srl: result = a >> shamt;
            default:         result = '0;
        endcase
    end

    // branches subtract the operands and look at this flag.
    assign zero = (result == '0);

endmodule

// ==== hw/rv_control.sv ====
`timescale 1ns/100ps

module rv_control (
    input  rv_pkg::opcode_e opcode,
    input  logic [2:0]      funct3,
    input  logic            bit30,
    output logic            reg_write,
    output logic            mem_write,
    output logic            alu_src_imm,
    output logic            branch,
    output logic            branch_ne,
    output rv_pkg::wb_src_e wb_src,
    output rv_pkg::a_src_e  a_src,
    output rv_pkg::alu_op_e alu_op
);

    rv_pkg::alu_op_e arith_op;

    // operation selected by funct3 for R-type and I-type arithmetic.
    // bit30 only means SUB for register-register instructions, since in
    // ADDI it is just a bit of the immediate.
    always_comb begin
        case (funct3)
            3'b000: begin
                if (opcode == rv_pkg::op_r && bit30) begin
                    arith_op = rv_pkg::alu_sub;
                end else begin
                    arith_op = rv_pkg::alu_add;
                end
            end
            3'b001:  arith_op = rv_pkg::alu_sll;
            3'b010:  arith_op = rv_pkg::alu_slt;
            3'b100:  arith_op = rv_pkg::alu_xor;
            3'b101:  arith_op = rv_pkg::alu_srl;
            3'b110:  arith_op = rv_pkg::alu_or;
            3'b111:  arith_op = rv_pkg::alu_and;
            default: arith_op = rv_pkg::alu_add;
        endcase
    end

    always_comb begin
        // everything off by default, so an unknown opcode is a no-op.
        reg_write   = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        branch      = 1'b0;
        branch_ne   = 1'b0;
        wb_src      = rv_pkg::wb_alu;
        a_src       = rv_pkg::a_rs1;
        alu_op      = rv_pkg::alu_add;
        case (opcode)
            rv_pkg::op_r: begin
                reg_write = 1'b1;
                alu_op    = arith_op;
            end
            rv_pkg::op_imm: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = arith_op;
            end
            rv_pkg::op_load: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                wb_src      = rv_pkg::wb_mem;
            end
            rv_pkg::op_store: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            rv_pkg::op_branch: begin
                branch    = 1'b1;
                branch_ne = funct3[0];
                alu_op    = rv_pkg::alu_sub;
            end
            rv_pkg::op_lui: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                a_src       = rv_pkg::a_zero;
            end
            rv_pkg::op_auipc: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                a_src       = rv_pkg::a_pc;
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile (
    input  logic                              CLK,
    input  logic                              RESET_N,
    input  logic [rv_pkg::reg_addr_width-1:0] rs1,
    input  logic [rv_pkg::reg_addr_width-1:0] rs2,
    input  logic [rv_pkg::reg_addr_width-1:0] rd,
    input  logic [rv_pkg::xlen-1:0]           wdata_rd,
    input  logic                              we,
    output logic [rv_pkg::xlen-1:0]           rdata1,
    output logic [rv_pkg::xlen-1:0]           rdata2
);

    // x0 has no storage, only x1 to x31 are held.
    logic [rv_pkg::xlen-1:0] regs [1:rv_pkg::reg_count-1];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < rv_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata_rd;
        end
    end

    // reads are combinational and see the old value during a write cycle.
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/rv_imm_gen.sv ====
`timescale 1ns/100ps

module rv_imm_gen (
    input  logic [rv_pkg::xlen-1:0] instr,
    input  rv_pkg::opcode_e         opcode,
    output logic [rv_pkg::xlen-1:0] imm
);

    localparam int xl = rv_pkg::xlen;

    always_comb begin
        case (opcode)
            rv_pkg::op_imm,
            rv_pkg::op_load: begin
                imm = {{(xl-12){instr[31]}}, instr[31:20]};
            end
            rv_pkg::op_store: begin
                imm = {{(xl-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            // branch offsets count in halfwords, so bit 0 is always clear.
            rv_pkg::op_branch: begin
                imm = {{(xl-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv_pkg::op_lui,
            rv_pkg::op_auipc: begin
                imm = {{(xl-32){instr[31]}}, instr[31:12], 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
    input  logic                          CLK,
    input  logic                          RESET_N,
    input  logic [rv_pkg::xlen-1:0]       q_rom,
    output logic [rv_pkg::addr_width-1:0] addr_rom,
    output logic [rv_pkg::addr_width-1:0] addr_ram,
    input  logic [rv_pkg::xlen-1:0]       q_ram,
    output logic [rv_pkg::xlen-1:0]       wdata,
    output logic                          wen
);

    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] pc_plus4;
    logic [rv_pkg::xlen-1:0] pc_target;
    logic [rv_pkg::xlen-1:0] next_pc;

    rv_pkg::opcode_e         opcode;
    logic                    reg_write;
    logic                    alu_src_imm;
    logic                    branch;
    logic                    branch_ne;
    rv_pkg::wb_src_e         wb_src;
    rv_pkg::a_src_e          a_src;
    rv_pkg::alu_op_e         alu_op;

    logic [rv_pkg::xlen-1:0] rdata1;
    logic [rv_pkg::xlen-1:0] rdata2;
    logic [rv_pkg::xlen-1:0] imm;
    logic [rv_pkg::xlen-1:0] alu_a;
    logic [rv_pkg::xlen-1:0] alu_b;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic                    alu_zero;
    logic [rv_pkg::xlen-1:0] wb_data;
    logic                    taken;

    assign opcode = rv_pkg::opcode_e'(q_rom[6:0]);

    rv_control u_control (
        .opcode      (opcode),
        .funct3      (q_rom[14:12]),
        .bit30       (q_rom[30]),
        .reg_write   (reg_write),
        .mem_write   (wen),
        .alu_src_imm (alu_src_imm),
        .branch      (branch),
        .branch_ne   (branch_ne),
        .wb_src      (wb_src),
        .a_src       (a_src),
        .alu_op      (alu_op)
    );

    rv_regfile u_regfile (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1      (q_rom[19:15]),
        .rs2      (q_rom[24:20]),
        .rd       (q_rom[11:7]),
        .wdata_rd (wb_data),
        .we       (reg_write),
        .rdata1   (rdata1),
        .rdata2   (rdata2)
    );

    rv_imm_gen u_imm_gen (
        .instr  (q_rom),
        .opcode (opcode),
        .imm    (imm)
    );

    // first operand is rs1, the PC for AUIPC, or zero for LUI.
    always_comb begin
        case (a_src)
            rv_pkg::a_pc:   alu_a = pc;
            rv_pkg::a_zero: alu_a = '0;
            default:        alu_a = rdata1;
        endcase
    end

    assign alu_b = alu_src_imm ? imm : rdata2;

    rv_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // data memory sees the effective address and the rs2 value.
    assign addr_ram = alu_result[rv_pkg::addr_width-1:0];
    assign wdata    = rdata2;

    assign wb_data = (wb_src == rv_pkg::wb_mem) ? q_ram : alu_result;

    // BEQ wants the zero flag set, BNE wants it clear.
    assign taken     = branch && (alu_zero != branch_ne);
    assign pc_plus4  = pc + rv_pkg::xlen'(4);
    assign pc_target = pc + imm;
    assign next_pc   = taken ? pc_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign addr_rom = pc[rv_pkg::addr_width-1:0];

    // fetches stay word aligned, including after a taken branch.
    assert property (@(posedge CLK) disable iff (!RESET_N) pc[1:0] == 2'b00);

endmodule

// ==== tb/tb_core.sv ====
`timescale 1ns/100ps

module tb_core;

    localparam int timeout_cycles = 400;

    logic                          CLK = 1'b0;
    logic                          RESET_N;
    logic [rv_pkg::xlen-1:0]       q_rom;
    logic [rv_pkg::addr_width-1:0] addr_rom;
    logic [rv_pkg::addr_width-1:0] addr_ram;
    logic [rv_pkg::xlen-1:0]       q_ram;
    logic [rv_pkg::xlen-1:0]       wdata;
    logic                          wen;

    logic [rv_pkg::xlen-1:0]       rom [0:255];
    logic [rv_pkg::xlen-1:0]       ram [0:255];
    logic                          preset_we;
    logic [7:0]                    preset_idx;
    logic [rv_pkg::xlen-1:0]       preset_val;
    logic [rv_pkg::addr_width-1:0] st_addr [$];
    logic [rv_pkg::xlen-1:0]       st_data [$];
    logic [rv_pkg::addr_width-1:0] exp_addr [$];
    logic [rv_pkg::xlen-1:0]       exp_data [$];
    logic [rv_pkg::addr_width-1:0] trace [$];
    logic [rv_pkg::addr_width-1:0] path [$];
    int                            errors;
    int                            wp;
    int                            sp;
    int                            st_first;

    rv_core UUT (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .q_rom    (q_rom),
        .addr_rom (addr_rom),
        .addr_ram (addr_ram),
        .q_ram    (q_ram),
        .wdata    (wdata),
        .wen      (wen)
    );

    always #10 CLK = ~CLK;

    // both memories answer combinationally from word addresses.
    assign q_rom = rom[addr_rom[9:2]];
    assign q_ram = ram[addr_ram[9:2]];

    // data memory write port. every store of the core is also logged here.
    always @(posedge CLK) begin
        if (wen) begin
            ram[addr_ram[9:2]] <= wdata;
            st_addr.push_back(addr_ram);
            st_data.push_back(wdata);
        end else if (preset_we) begin
            ram[preset_idx] <= preset_val;
        end
    end

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_r};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // expected result of an arithmetic instruction under the RV32I rules.
    function automatic logic [31:0] ref_op(logic [2:0] f3, logic sub, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_word(string name, logic [rv_pkg::xlen-1:0] exp,
                              logic [rv_pkg::xlen-1:0] act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(string name, logic [rv_pkg::addr_width-1:0] exp,
                              logic [rv_pkg::addr_width-1:0] act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic put(logic [31:0] instr);
        rom[8'(wp >> 2)] = instr;
        wp += 4;
    endtask

    // LUI plus ADDI, with the upper part rounded so the signed low part adds up.
    task automatic load_const(logic [4:0] rd, logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        put(enc_u(upper[31:12], rd, rv_pkg::op_lui));
        put(enc_i(value[11:0], rd, 3'b000, rd, rv_pkg::op_imm));
    endtask

    task automatic store_result(logic [4:0] rs, logic [31:0] expected);
        put(enc_s(12'(sp), rs, 0));
        exp_addr.push_back(10'(sp));
        exp_data.push_back(expected);
        sp += 4;
    endtask

    task automatic preset_word(logic [7:0] idx, logic [31:0] value);
        preset_idx = idx;
        preset_val = value;
        preset_we = 1'b1;
        @(negedge CLK);
        preset_we = 1'b0;
    endtask

    // holds the core in reset and fills the ROM with ADDI x0 no-ops.
    task automatic begin_program;
        RESET_N = 1'b0;
        for (int i = 0; i < 256; i++) begin
            rom[8'(i)] = enc_i(12'h000, 0, 3'b000, 0, rv_pkg::op_imm);
        end
        wp = 4;
        sp = 'h100;
        exp_addr.delete();
        exp_data.delete();
        path.delete();
    endtask

    task automatic compare_stores;
        int n;
        n = st_addr.size() - st_first;
        if (n != exp_addr.size()) begin
            $display("Wrong number of stores at %0t: expected %0d, saw %0d.",
                     $time, exp_addr.size(), n);
            errors++;
        end else begin
            for (int i = 0; i < n; i++) begin
                check_addr("addr_ram", exp_addr[i], st_addr[st_first + i]);
                check_word("wdata", exp_data[i], st_data[st_first + i]);
            end
        end
    endtask

    task automatic compare_path;
        if (trace.size() != path.size()) begin
            $display("The fetch path had %0d steps where %0d were expected.",
                     trace.size(), path.size());
            errors++;
        end else begin
            for (int i = 0; i < path.size(); i++) begin
                check_addr("addr_rom", path[i], trace[i]);
            end
        end
    endtask

    // ends the program with a self-looping BEQ, releases reset and runs until it is reached.
    task automatic run_program;
        logic [rv_pkg::addr_width-1:0] end_addr;
        int n;
        end_addr = 10'(wp);
        put(enc_b(13'd0, 0, 0, 3'b000));
        st_first = st_addr.size();
        trace.delete();
        repeat (8) @(negedge CLK);
        RESET_N = 1'b1;
        trace.push_back(addr_rom);
        n = 0;
        while (addr_rom != end_addr && n < timeout_cycles) begin
            @(negedge CLK);
            trace.push_back(addr_rom);
            n++;
        end
        if (addr_rom != end_addr) begin
            $display("Timeout at %0t: the program never reached its final branch.", $time);
            errors++;
        end
        compare_stores();
    endtask

    task automatic test_fetch;
        begin_program();
        wp = 48;
        for (int p = 0; p <= 48; p += 4) begin
            path.push_back(10'(p));
        end
        run_program();
        compare_path();
    endtask

    task automatic test_arith;
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] k;
        logic [31:0] k_ext;
        begin_program();
        a = $urandom();
        b = $urandom();
        k = 12'($urandom());
        k_ext = {{20{k[11]}}, k};
        load_const(1, a);
        load_const(2, b);
        // funct3 3 is SLTU, and I-type shifts are not part of the subset.
        for (int f = 0; f < 8; f++) begin
            if (f != 3) begin
                put(enc_r(7'h00, 2, 1, 3'(f), 3));
                store_result(3, ref_op(3'(f), 1'b0, a, b));
            end
            if (f != 1 && f != 3 && f != 5) begin
                put(enc_i(k, 1, 3'(f), 4, rv_pkg::op_imm));
                store_result(4, ref_op(3'(f), 1'b0, a, k_ext));
            end
        end
        put(enc_r(7'h20, 2, 1, 3'b000, 3));
        store_result(3, ref_op(3'b000, 1'b1, a, b));
        run_program();
    endtask

    task automatic test_loads;
        logic [31:0] words [4];
        logic [11:0] ks [4];
        for (int i = 0; i < 4; i++) begin
            words[i] = $urandom();
            ks[i] = 12'($urandom());
            preset_word(8'(128 + i), words[i]);
        end
        begin_program();
        for (int i = 0; i < 4; i++) begin
            put(enc_i(12'(512 + 4 * i), 0, 3'b010, 5, rv_pkg::op_load));
            put(enc_i(ks[i], 5, 3'b000, 6, rv_pkg::op_imm));
            store_result(6, words[i] + {{20{ks[i][11]}}, ks[i]});
        end
        run_program();
    endtask

    task automatic test_branch;
        logic [31:0] a;
        begin_program();
        a = $urandom();
        load_const(1, a);
        load_const(2, a);
        load_const(3, a + 1);
        // BEQ taken at 28, so the stores at 32 and 36 must never happen.
        put(enc_b(13'd12, 2, 1, 3'b000));
        put(enc_s(12'h3f0, 1, 0));
        put(enc_s(12'h3f4, 1, 0));
        put(enc_b(13'd8, 3, 1, 3'b000));
        store_result(1, a);
        // BNE taken at 48 skips 52 and 56, then BNE not taken at 60.
        put(enc_b(13'd12, 3, 1, 3'b001));
        put(enc_s(12'h3f8, 3, 0));
        put(enc_s(12'h3fc, 3, 0));
        put(enc_b(13'd8, 2, 1, 3'b001));
        store_result(3, a + 1);
        for (int p = 0; p <= 68; p += 4) begin
            if (!(p > 28 && p < 40) && p != 52 && p != 56)
                path.push_back(10'(p));
        end
        run_program();
        compare_path();
    endtask

    task automatic test_upper;
        logic [19:0] u;
        int pc_auipc;
        begin_program();
        u = 20'($urandom());
        put(enc_u(u, 7, rv_pkg::op_lui));
        store_result(7, {u, 12'h000});
        pc_auipc = wp;
        put(enc_u(u, 8, rv_pkg::op_auipc));
        store_result(8, {u, 12'h000} + 32'(pc_auipc));
        // a write to x0 is dropped, so x0 still stores as zero.
        put(enc_i(12'h07b, 0, 3'b000, 0, rv_pkg::op_imm));
        store_result(0, 32'h0);
        run_program();
    endtask

    initial begin
        RESET_N = 1'b0;
        preset_we = 1'b0;
        preset_idx = '0;
        preset_val = '0;
        errors = 0;
        st_first = 0;
        void'($urandom(12569));
        test_fetch();
        test_arith();
        test_loads();
        test_branch();
        test_upper();
        $display("Tests finished with %0d errors.", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/rv_pkg.sv
hw/rv_alu.sv
hw/rv_control.sv
hw/rv_regfile.sv
hw/rv_imm_gen.sv
hw/rv_core.sv
tb/tb_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the core testbench with Verilator, runs it into sim.log and checks the result.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_core -f compile.f -o tb_core

status=0
./obj_dir/tb_core > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
